//--- build.f
hdl/cachePkg.sv
hdl/memPort.sv
hdl/cacheArrays.sv
hdl/missControl.sv
hdl/dataCache.sv
tb/memModel.sv
tb/cacheTb.sv

//--- hdl/cacheArrays.sv
`timescale 1ns/100ps
`default_nettype none

module cacheArrays (
	input wire logic clk,
	input wire logic reset,
	input wire cachePkg::addrT lookupAddr,
	input wire cachePkg::wordT writeWord,
	input wire logic writeHit,
	input wire logic touch,
	input wire logic fill,
	input wire cachePkg::lineT fillLine,
	input wire logic cleanVictim,
	output logic hit,
	output cachePkg::wordT readWord,
	output logic victimDirty,
	output cachePkg::addrT victimAddr,
	output cachePkg::lineT victimLine
);

	localparam int wordBits = $bits(cachePkg::wordT);

	// per way state bits, indexed [way][set]
	logic [cachePkg::setCount-1:0] valid [2];
	logic [cachePkg::setCount-1:0] dirty [2];
	logic [cachePkg::setCount-1:0] lru; // holds the least recently used way

	cachePkg::tagT tags [2][cachePkg::setCount];
	cachePkg::lineT lines [2][cachePkg::setCount];

	cachePkg::tagT reqTag;
	cachePkg::indexT idx;
	cachePkg::wordSelT wordSel;
	logic [1:0] wayHit;
	cachePkg::wayT hitWay;
	cachePkg::wayT victimWay;

	assign reqTag = lookupAddr[cachePkg::addrBits-1 -: cachePkg::tagBits];
	assign idx = lookupAddr[cachePkg::offsetBits +: cachePkg::indexBits];
	assign wordSel = lookupAddr[cachePkg::offsetBits-1:2];

	assign wayHit[0] = valid[0][idx] && (tags[0][idx] == reqTag);
	assign wayHit[1] = valid[1][idx] && (tags[1][idx] == reqTag);
	assign hit = |wayHit;
	assign hitWay = wayHit[1];

	assign readWord = lines[hitWay][idx][wordSel*wordBits +: wordBits];

	// empty way first, way 0 before way 1, then LRU
	always_comb begin
		if (!valid[0][idx])
			victimWay = 1'b0;
		else if (!valid[1][idx])
			victimWay = 1'b1;
		else
			victimWay = lru[idx];
	end

	assign victimDirty = valid[victimWay][idx] && dirty[victimWay][idx];
	assign victimAddr = {tags[victimWay][idx], idx, {cachePkg::offsetBits{1'b0}}};
	assign victimLine = lines[victimWay][idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid[0] <= '0;
			valid[1] <= '0;
			dirty[0] <= '0;
			dirty[1] <= '0;
			lru <= '0;
		end else begin
			if (writeHit) begin
				dirty[hitWay][idx] <= 1'b1;
				lru[idx] <= ~hitWay;
			end else if (touch) begin
				lru[idx] <= ~hitWay;
			end else if (fill) begin
				valid[victimWay][idx] <= 1'b1;
				dirty[victimWay][idx] <= 1'b0; // refilled lines come in clean
				lru[idx] <= ~victimWay;
			end else if (cleanVictim) begin
				dirty[victimWay][idx] <= 1'b0;
			end
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (writeHit)
			lines[hitWay][idx][wordSel*wordBits +: wordBits] <= writeWord;
		if (fill) begin
			tags[victimWay][idx] <= reqTag;
			lines[victimWay][idx] <= fillLine;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cachePkg.sv
`default_nettype none

package cachePkg;

	// geometry
	localparam int addrBits = 32;
	localparam int setCount = 16;
	localparam int wordsPerLine = 4;
	localparam int offsetBits = 4; // byte within a line
	localparam int indexBits = 4;
	localparam int tagBits = addrBits - indexBits - offsetBits;

	typedef logic [addrBits-1:0] addrT;
	typedef logic [31:0] wordT;
	typedef logic [tagBits-1:0] tagT;
	typedef logic [indexBits-1:0] indexT;
	typedef logic [1:0] wordSelT;
	typedef logic [wordsPerLine*32-1:0] lineT; // word 0 in the low bits
	typedef logic wayT;

	// miss sequencer states
	typedef enum logic [2:0] {
		idle,
		lookup,
		writeBack,
		refill,
		retry
	} ctrlStateT;

endpackage

`default_nettype wire

//--- hdl/dataCache.sv
`timescale 1ns/100ps
`default_nettype none

module dataCache (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire cachePkg::addrT paddr,
	input wire cachePkg::wordT pwdata,
	output cachePkg::wordT prdata,
	output logic pready,
	output logic memReq,
	output logic memWrite,
	output cachePkg::addrT memAddr,
	output cachePkg::lineT memWdata,
	input wire logic memAck,
	input wire cachePkg::lineT memRdata
);

	cachePkg::addrT lookupAddr;
	cachePkg::wordT writeWord;
	cachePkg::wordT readWord;
	cachePkg::lineT fillLine;
	cachePkg::lineT victimLine;
	cachePkg::addrT victimAddr;
	logic writeHit;
	logic touch;
	logic fill;
	logic cleanVictim;
	logic hit;
	logic victimDirty;

	// memory port handshake
	logic start;
	logic startWrite;
	cachePkg::addrT startAddr;
	cachePkg::lineT startLine;
	logic done;
	cachePkg::lineT doneLine;

	missControl ctrl (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready),
		.hit(hit), .readWord(readWord), .victimDirty(victimDirty),
		.victimAddr(victimAddr), .victimLine(victimLine),
		.lookupAddr(lookupAddr), .writeWord(writeWord), .writeHit(writeHit), .touch(touch),
		.fill(fill), .fillLine(fillLine), .cleanVictim(cleanVictim),
		.start(start), .startWrite(startWrite), .startAddr(startAddr), .startLine(startLine),
		.done(done), .doneLine(doneLine)
	);

	cacheArrays arrays (
		.clk(clk), .reset(reset),
		.lookupAddr(lookupAddr), .writeWord(writeWord), .writeHit(writeHit), .touch(touch),
		.fill(fill), .fillLine(fillLine), .cleanVictim(cleanVictim),
		.hit(hit), .readWord(readWord), .victimDirty(victimDirty),
		.victimAddr(victimAddr), .victimLine(victimLine)
	);

	memPort port (
		.clk(clk), .reset(reset),
		.start(start), .startWrite(startWrite), .startAddr(startAddr), .startLine(startLine),
		.memAck(memAck), .memRdata(memRdata),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
		.done(done), .doneLine(doneLine)
	);

endmodule

`default_nettype wire

//--- hdl/memPort.sv
`timescale 1ns/100ps
`default_nettype none

module memPort (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic startWrite,
	input wire cachePkg::addrT startAddr,
	input wire cachePkg::lineT startLine,
	input wire logic memAck,
	input wire cachePkg::lineT memRdata,
	output logic memReq,
	output logic memWrite,
	output cachePkg::addrT memAddr,
	output cachePkg::lineT memWdata,
	output logic done,
	output cachePkg::lineT doneLine
);

	logic ackNow;

	assign ackNow = memReq && memAck;

	always_ff @(posedge clk) begin
		if (reset) begin
			memReq <= 1'b0;
			memWrite <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= ackNow; // one cycle after the ack
			if (start) begin
				memReq <= 1'b1;
				memWrite <= startWrite;
			end else if (ackNow) begin
				memReq <= 1'b0;
			end
		end
	end

	// request fields stay put until the ack
	always_ff @(posedge clk) begin
		if (start) begin
			memAddr <= startAddr;
			memWdata <= startLine;
		end
		if (ackNow)
			doneLine <= memRdata; // refill capture
	end

endmodule

`default_nettype wire

//--- hdl/missControl.sv
`timescale 1ns/100ps
`default_nettype none

module missControl (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire cachePkg::addrT paddr,
	input wire cachePkg::wordT pwdata,
	output cachePkg::wordT prdata,
	output logic pready,
	input wire logic hit,
	input wire cachePkg::wordT readWord,
	input wire logic victimDirty,
	input wire cachePkg::addrT victimAddr,
	input wire cachePkg::lineT victimLine,
	output cachePkg::addrT lookupAddr,
	output cachePkg::wordT writeWord,
	output logic writeHit,
	output logic touch,
	output logic fill,
	output cachePkg::lineT fillLine,
	output logic cleanVictim,
	output logic start,
	output logic startWrite,
	output cachePkg::addrT startAddr,
	output cachePkg::lineT startLine,
	input wire logic done,
	input wire cachePkg::lineT doneLine
);

	cachePkg::ctrlStateT state;
	cachePkg::ctrlStateT nextState;
	cachePkg::addrT refillAddr;
	logic access;

	assign access = psel && penable;
	assign refillAddr = {paddr[cachePkg::addrBits-1:cachePkg::offsetBits],
		{cachePkg::offsetBits{1'b0}}};

	// the master holds paddr until pready, so the arrays look it up directly
	assign lookupAddr = paddr;
	assign writeWord = pwdata;
	assign prdata = readWord;
	assign fillLine = doneLine;
	assign startLine = victimLine; // only used by write-back requests

	assign pready = (state == cachePkg::lookup) && access && hit; // zero wait on a hit
	assign writeHit = pready && pwrite;
	assign touch = pready && !pwrite;

	always_comb begin
		nextState = state;
		start = 1'b0;
		startWrite = 1'b0;
		startAddr = refillAddr;
		fill = 1'b0;
		cleanVictim = 1'b0;
		case (state)
			cachePkg::idle: begin
				if (psel && !penable)
					nextState = cachePkg::lookup;
			end
			cachePkg::lookup: begin
				if (!psel) begin
					nextState = cachePkg::idle;
				end else if (penable) begin
					if (hit) begin
						nextState = cachePkg::idle;
					end else begin
						start = 1'b1;
						if (victimDirty) begin // evict first
							startWrite = 1'b1;
							startAddr = victimAddr;
							nextState = cachePkg::writeBack;
						end else begin
							nextState = cachePkg::refill;
						end
					end
				end
			end
			cachePkg::writeBack: begin
				if (done) begin
					cleanVictim = 1'b1;
					start = 1'b1; // port is idle again in the done cycle
					nextState = cachePkg::refill;
				end
			end
			cachePkg::refill: begin
				if (done) begin
					fill = 1'b1;
					nextState = cachePkg::retry;
				end
			end
			cachePkg::retry:
				nextState = cachePkg::lookup; // access then completes as a hit
			default:
				nextState = cachePkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= cachePkg::idle;
		else
			state <= nextState;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -f build.f --top-module cacheTb -o cacheSim

out=$(./obj_dir/cacheSim)
printf '%s\n' "$out"

# status comes from the search for the pass line
printf '%s\n' "$out" | grep -qx 'Simulation passed'

//--- tb/cacheTb.sv
`timescale 1ns/100ps
`default_nettype none

module cacheTb;

	localparam int memWords = 1024;
	localparam int waitLimit = 100; // cycles allowed per transfer
	localparam cachePkg::wordT writtenWord = 32'h5a5a_1234;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	cachePkg::addrT paddr;
	cachePkg::wordT pwdata;
	cachePkg::wordT prdata;
	logic pready;
	logic memReq;
	logic memWrite;
	cachePkg::addrT memAddr;
	cachePkg::lineT memWdata;
	logic memAck;
	cachePkg::lineT memRdata;
	int readCount;
	int writeCount;
	cachePkg::addrT lastWbAddr;
	cachePkg::lineT lastWbLine;

	cachePkg::wordT mirror [memWords]; // preload image of main memory
	integer seed;
	int valueErrors;
	int timeoutErrors;

	dataCache DUT (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
		.memAck(memAck), .memRdata(memRdata)
	);

	memModel memory (
		.clk(clk), .reset(reset),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
		.memAck(memAck), .memRdata(memRdata),
		.readCount(readCount), .writeCount(writeCount),
		.lastWbAddr(lastWbAddr), .lastWbLine(lastWbLine)
	);

	always #10 clk = ~clk;

	task automatic finishRun();
		$display("errors: %0d mismatches, %0d timeouts", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic checkWord(input string testName, input cachePkg::wordT expected,
		input cachePkg::wordT actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, got %h", testName, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkAddr(input string testName, input cachePkg::addrT expected,
		input cachePkg::addrT actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, got %h", testName, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkCount(input string testName, input int expected, input int actual);
		if (actual != expected) begin
			$display("[FAIL] %s: expected %0d, got %0d", testName, expected, actual);
			valueErrors++;
		end
	endtask

	function automatic cachePkg::wordT preloadWord(input cachePkg::addrT addr);
		return mirror[addr[11:2]];
	endfunction

	task automatic applyReset();
		@(posedge clk);
		#2;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	// setup cycle, then access cycles until pready
	task automatic apbTransfer(input logic isWrite, input cachePkg::addrT addr,
		input cachePkg::wordT wdata, output cachePkg::wordT rdata, output int waitStates);
		waitStates = 0;
		rdata = '0;
		@(posedge clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = isWrite;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		while (!pready && waitStates < waitLimit) begin
			@(negedge clk);
			waitStates++;
		end
		if (!pready) begin
			$display("timeout: DUT never raised pready within %0d cycles for address %h",
				waitLimit, addr);
			timeoutErrors++;
		end else begin
			rdata = prdata;
		end
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input cachePkg::addrT addr, output cachePkg::wordT data,
		output int waitStates);
		apbTransfer(1'b0, addr, '0, data, waitStates);
	endtask

	task automatic apbWrite(input cachePkg::addrT addr, input cachePkg::wordT data,
		output int waitStates);
		cachePkg::wordT unused;
		apbTransfer(1'b1, addr, data, unused, waitStates);
	endtask

	task automatic readExpect(input string testName, input cachePkg::addrT addr,
		input cachePkg::wordT expected, input int expRefills);
		cachePkg::wordT data;
		int waits;
		int reads0;
		reads0 = readCount;
		apbRead(addr, data, waits);
		checkWord($sformatf("%s data", testName), expected, data);
		checkCount($sformatf("%s refills", testName), expRefills, readCount - reads0);
		if (expRefills == 0)
			checkCount($sformatf("%s wait states", testName), 0, waits); // hits are zero wait
	endtask

	task automatic coldRead();
		int writes0;
		writes0 = writeCount;
		readExpect("coldRead", 32'h0000_0124, preloadWord(32'h0000_0124), 1);
		checkCount("coldRead write-backs", 0, writeCount - writes0);
	endtask

	task automatic writeThenRead();
		int waits;
		int reads0;
		int writes0;
		reads0 = readCount;
		writes0 = writeCount;
		apbWrite(32'h0000_0238, writtenWord, waits); // write miss, refill then hit
		checkCount("writeThenRead write refills", 1, readCount - reads0);
		readExpect("writeThenRead", 32'h0000_0238, writtenWord, 0);
		checkCount("writeThenRead write-backs", 0, writeCount - writes0);
	endtask

	// index 3 holds the dirty line from writeThenRead
	task automatic dirtyEviction();
		int writes0;
		cachePkg::wordT expected;
		writes0 = writeCount;
		readExpect("dirtyEviction fill", 32'h0000_0534, preloadWord(32'h0000_0534), 1);
		checkCount("dirtyEviction early write-backs", 0, writeCount - writes0);
		readExpect("dirtyEviction victim", 32'h0000_063c, preloadWord(32'h0000_063c), 1);
		checkCount("dirtyEviction write-backs", 1, writeCount - writes0);
		checkAddr("dirtyEviction write-back address", 32'h0000_0230, lastWbAddr);
		for (int w = 0; w < 4; w++) begin
			expected = (w == 2) ? writtenWord : preloadWord(32'h0000_0230 + w * 4);
			checkWord($sformatf("dirtyEviction write-back word %0d", w), expected,
				lastWbLine[w*32 +: 32]);
		end
		writes0 = writeCount;
		readExpect("dirtyEviction refetch", 32'h0000_0238, writtenWord, 1);
		checkCount("dirtyEviction refetch write-backs", 0, writeCount - writes0);
	endtask

	task automatic lruReplacement();
		cachePkg::addrT a;
		cachePkg::addrT b;
		cachePkg::addrT c;
		int writes0;
		a = 32'h0000_0154;
		b = 32'h0000_0258;
		c = 32'h0000_035c;
		writes0 = writeCount;
		readExpect("lruReplacement A first", a, preloadWord(a), 1);
		readExpect("lruReplacement B first", b, preloadWord(b), 1);
		readExpect("lruReplacement A again", a, preloadWord(a), 0);
		readExpect("lruReplacement C evicts B", c, preloadWord(c), 1);
		readExpect("lruReplacement A kept", a, preloadWord(a), 0);
		readExpect("lruReplacement B refetched", b, preloadWord(b), 1);
		checkCount("lruReplacement write-backs", 0, writeCount - writes0);
	endtask

	task automatic resetInvalidates();
		readExpect("resetInvalidates warm", 32'h0000_0154, preloadWord(32'h0000_0154), 0);
		applyReset();
		readExpect("resetInvalidates cold", 32'h0000_0154, preloadWord(32'h0000_0154), 1);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		valueErrors = 0;
		timeoutErrors = 0;
		seed = 32'hd690f7f0;
		for (int i = 0; i < memWords; i++)
			mirror[i] = $random(seed) ^ (i * 4); // same rule as the memory preload
		applyReset();
		coldRead();
		writeThenRead();
		dirtyEviction();
		lruReplacement();
		resetInvalidates();
		finishRun();
	end

endmodule

`default_nettype wire

//--- tb/memModel.sv
`timescale 1ns/100ps
`default_nettype none

module memModel (
	input wire logic clk,
	input wire logic reset,
	input wire logic memReq,
	input wire logic memWrite,
	input wire cachePkg::addrT memAddr,
	input wire cachePkg::lineT memWdata,
	output logic memAck,
	output cachePkg::lineT memRdata,
	output int readCount,
	output int writeCount,
	output cachePkg::addrT lastWbAddr,
	output cachePkg::lineT lastWbLine
);

	localparam int memWords = 1024; // 4 KB window at address 0

	cachePkg::wordT mem [memWords];
	integer seed;
	logic busy;
	int waitLeft;

	// each word is its byte address xor a random value
	initial begin
		seed = 32'hd690f7f0;
		for (int i = 0; i < memWords; i++)
			mem[i] = $random(seed) ^ (i * 4);
	end

	always @(posedge clk) begin
		if (reset) begin
			memAck <= 1'b0;
			memRdata <= '0;
			busy <= 1'b0;
			waitLeft <= 0;
			readCount <= 0;
			writeCount <= 0;
			lastWbAddr <= '0;
			lastWbLine <= '0;
		end else begin
			memAck <= 1'b0;
			if (memAck) begin
				busy <= 1'b0; // port drops memReq at this edge
			end else if (memReq && !busy) begin
				busy <= 1'b1;
				waitLeft <= $unsigned($random(seed)) % 4; // ack 1 to 4 cycles later
			end else if (busy) begin
				if (waitLeft == 0) begin
					memAck <= 1'b1;
					if (memWrite) begin
						writeCount <= writeCount + 1;
						lastWbAddr <= memAddr;
						lastWbLine <= memWdata;
						mem[{memAddr[11:4], 2'd0}] <= memWdata[31:0];
						mem[{memAddr[11:4], 2'd1}] <= memWdata[63:32];
						mem[{memAddr[11:4], 2'd2}] <= memWdata[95:64];
						mem[{memAddr[11:4], 2'd3}] <= memWdata[127:96];
					end else begin
						readCount <= readCount + 1;
						memRdata <= {mem[{memAddr[11:4], 2'd3}], mem[{memAddr[11:4], 2'd2}],
							mem[{memAddr[11:4], 2'd1}], mem[{memAddr[11:4], 2'd0}]};
					end
				end else begin
					waitLeft <= waitLeft - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire
